// File: src.f
leaf_pkg.sv
port_fifo.sv
leaf_packet_rx.sv
pair_sum_kernel.sv
leaf_packet_tx.sv
leaf_i6o5.sv
tb_leaf.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_leaf -f src.f
	@out=$$(./obj_dir/Vtb_leaf); \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// File: tb_leaf.sv
module tb_leaf;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_in      = 6;
    localparam int num_out     = 5;
    localparam int credit_init = 4;
    localparam int max_cycles  = 2000;   // Whole test needs well under 400

    logic                             clk;
    logic                             arst_n;
    logic                             resend;
    logic [leaf_pkg::packet_bits-1:0] din;
    logic [leaf_pkg::packet_bits-1:0] dout;
    leaf_pkg::leaf_packet_u           dout_pkt;

    logic [31:0] in_q [num_in][$];   // Words written per data port
    int          sent_count [num_out];
    int          allowed [num_out];
    logic        route_known [num_out];
    logic [4:0]  exp_leaf [num_out];
    logic [3:0]  exp_port [num_out];
    logic        routes_set;
    logic        timed_out;
    int          errors;
    int          checked;
    int          cycles;
    int          seed;

    leaf_i6o5 #(
        .num_in_ports(num_in), .num_out_ports(num_out),
        .fifo_depth(8), .credit_init(credit_init)
    ) leaf_i6o5_inst (
        .clk, .arst_n, .din, .dout, .resend
    );

    assign dout_pkt = dout;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic finish_run();
        $display("Errors: %0d, packets checked: %0d, cycles: %0d", errors, checked, cycles);
        if (errors == 0 && !timed_out)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            timed_out = 1'b1;
            $display("Timeout: run did not complete within %0d cycles", max_cycles);
            finish_run();
        end
    end

    task automatic send_data(input int port, input logic [31:0] payload);
        leaf_pkg::leaf_packet_u pkt;
        pkt = '0;
        pkt.data.vld     = 1'b1;
        pkt.data.port    = 4'(port);
        pkt.data.payload = payload;
        if (port >= 1 && port <= num_in)
            in_q[port-1].push_back(payload);   // Ports above six are dropped
        @(posedge clk);
        #1 din = pkt;
    endtask

    task automatic send_ctrl(input logic [6:0] opcode, input int out_port,
                             input logic [4:0] dest_leaf, input logic [3:0] dest_port,
                             input logic [7:0] amount);
        leaf_pkg::leaf_packet_u pkt;
        pkt = '0;
        pkt.ctrl.vld       = 1'b1;
        pkt.ctrl.port      = 4'(leaf_pkg::ctrl_port);
        pkt.ctrl.opcode    = opcode;
        pkt.ctrl.out_port  = 4'(out_port);
        pkt.ctrl.dest_leaf = dest_leaf;
        pkt.ctrl.dest_port = dest_port;
        pkt.ctrl.amount    = amount;
        @(posedge clk);
        #1 din = pkt;
    endtask

    task automatic set_route(input int k);
        exp_leaf[k]    = 5'(20 + k);
        exp_port[k]    = 4'(k + 2);
        route_known[k] = 1'b1;
        routes_set     = 1'b1;
        send_ctrl(7'(leaf_pkg::op_route), k, exp_leaf[k], exp_port[k], 8'd0);
    endtask

    task automatic grant_credit(input int amount);
        for (int k = 0; k < num_out; k++) begin
            allowed[k] += amount;
            send_ctrl(7'(leaf_pkg::op_credit), k, 5'd0, 4'd0, 8'(amount));
        end
    endtask

    task automatic send_round(input int rounds);
        for (int r = 0; r < rounds; r++)
            for (int p = 1; p <= num_in; p++)
                send_data(p, $random(seed));
    endtask

    task automatic idle_cycles(input int n);
        @(posedge clk);
        #1 din = '0;
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_sent(input int target);
        bit done;
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = 1'b1;
            for (int k = 0; k < num_out; k++)
                if (sent_count[k] < target)
                    done = 1'b0;
        end
    endtask

    task automatic check_counts(input int target);
        for (int k = 0; k < num_out; k++)
            assert (sent_count[k] == target) else begin
                errors++;
                $display("Mismatch at %0t: packets from output %0d expected %0d actual %0d",
                         $time, k, target, sent_count[k]);
            end
    endtask

    function automatic int route_owner(input logic [4:0] leaf, input logic [3:0] port);
        int owner;
        owner = -1;
        for (int k = 0; k < num_out; k++)
            if (route_known[k] && exp_leaf[k] == leaf && exp_port[k] == port)
                owner = k;
        return owner;
    endfunction

    task automatic check_packet(input leaf_pkg::leaf_packet_u pkt);
        int          k;
        int          n;
        logic [31:0] exp_sum;
        k = route_owner(pkt.data.leaf, pkt.data.port);
        checked++;
        if (k < 0) begin
            errors++;
            $display("At %0t dout went to leaf %0d port %0d, which no route names",
                     $time, pkt.data.leaf, pkt.data.port);
        end else begin
            n = sent_count[k];
            sent_count[k]++;
            assert (n < allowed[k]) else begin
                errors++;
                $display("At %0t output %0d sent more packets than its credit", $time, k);
            end
            assert (pkt.data.tag == 7'(n)) else begin
                errors++;
                $display("Mismatch at %0t: dout.tag expected %0d actual %0d",
                         $time, 7'(n), pkt.data.tag);
            end
            if (n < in_q[k].size() && n < in_q[k+1].size()) begin
                exp_sum = in_q[k][n] + in_q[k+1][n];
                assert (pkt.data.payload == exp_sum) else begin
                    errors++;
                    $display("Mismatch at %0t: dout.payload expected %h actual %h",
                             $time, exp_sum, pkt.data.payload);
                end
            end else begin
                errors++;
                $display("At %0t output %0d sent a result without an input pair", $time, k);
            end
        end
    endtask

    // Mid-cycle, after resend and dout have settled
    always @(negedge clk) begin
        if (arst_n && dout_pkt.data.vld)
            check_packet(dout_pkt);
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        !routes_set |-> !dout[leaf_pkg::packet_bits-1])
    else begin
        errors++;
        $display("At %0t dout carried a packet before any route was set", $time);
    end

    assert property (@(posedge clk) disable iff (!arst_n) resend |-> dout == '0)
    else begin
        errors++;
        $display("Mismatch at %0t: dout expected 0 actual %h", $time, $sampled(dout));
    end

    initial begin
        seed       = 32'h39a1_304a;
        din        = '0;
        resend     = 1'b0;
        arst_n     = 1'b0;
        routes_set = 1'b0;
        timed_out  = 1'b0;
        errors     = 0;
        checked    = 0;
        cycles     = 0;
        for (int k = 0; k < num_out; k++) begin
            sent_count[k]  = 0;
            allowed[k]     = credit_init;
            route_known[k] = 1'b0;
        end
        repeat (4) @(posedge clk);
        #1 arst_n = 1'b1;
        assert (dout == '0) else begin
            errors++;
            $display("Mismatch at %0t: dout expected 0 actual %h", $time, dout);
        end

        // No routes yet, so nothing may leave
        send_round(2);
        send_ctrl(7'd5, 0, 5'd3, 4'd2, 8'd50);
        send_data(7, $random(seed));
        send_data(15, $random(seed));
        idle_cycles(20);

        for (int k = 0; k < num_out; k++)
            set_route(k);
        send_ctrl(7'h7f, 2, 5'd31, 4'd15, 8'd200);   // Unknown opcode
        send_round(4);
        idle_cycles(0);
        wait_sent(credit_init);
        idle_cycles(30);
        check_counts(credit_init);

        grant_credit(2);
        idle_cycles(0);
        wait_sent(credit_init + 2);
        send_round(3);
        idle_cycles(30);
        check_counts(credit_init + 2);

        // Resend while the last results are leaving
        grant_credit(3);
        #1 resend = 1'b1;
        idle_cycles(12);
        #1 resend = 1'b0;
        wait_sent(credit_init + 5);
        idle_cycles(20);
        check_counts(credit_init + 5);
        finish_run();
    end

endmodule

// File: leaf_i6o5.sv
module leaf_i6o5 #(
    parameter int num_in_ports  = 6,
    parameter int num_out_ports = 5,
    parameter int fifo_depth    = 8,
    parameter int credit_init   = 4
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic [leaf_pkg::packet_bits-1:0] din,
    output logic [leaf_pkg::packet_bits-1:0] dout,
    input  logic                             resend
);

    localparam int w = leaf_pkg::payload_bits;

    logic [num_in_ports-1:0]            fifo_we;
    logic [w-1:0]                       fifo_wdata;
    logic [num_in_ports*w-1:0]          in_data;
    logic [num_in_ports-1:0]            in_vld;
    logic [num_in_ports-1:0]            in_ack;
    logic [num_out_ports*w-1:0]         out_data;
    logic [num_out_ports-1:0]           out_vld;
    logic [num_out_ports-1:0]           out_ack;
    logic                               route_we;
    logic [leaf_pkg::port_bits-1:0]     route_port;
    logic [leaf_pkg::leaf_bits-1:0]     route_leaf;
    logic [leaf_pkg::port_bits-1:0]     route_dport;
    logic                               credit_we;
    logic [leaf_pkg::port_bits-1:0]     credit_port;
    logic [leaf_pkg::credit_bits-1:0]   credit_amount;

    leaf_packet_rx #(
        .num_in_ports(num_in_ports)
    ) u_rx (
        .clk, .arst_n, .din,
        .fifo_we, .fifo_wdata,
        .route_we, .route_port, .route_leaf, .route_dport,
        .credit_we, .credit_port, .credit_amount
    );

    for (genvar i = 0; i < num_in_ports; i++) begin : g_fifo
        port_fifo #(
            .fifo_depth(fifo_depth)
        ) u_fifo (
            .clk, .arst_n,
            .wr_en(fifo_we[i]), .wr_data(fifo_wdata), .ack(in_ack[i]),
            .data(in_data[i*w +: w]), .vld(in_vld[i]), .full()
        );
    end

    pair_sum_kernel #(
        .num_in_ports(num_in_ports),
        .num_out_ports(num_out_ports)
    ) u_kernel (
        .clk, .arst_n,
        .in_data, .in_vld, .in_ack,
        .out_data, .out_vld, .out_ack
    );

    leaf_packet_tx #(
        .num_out_ports(num_out_ports),
        .credit_init(credit_init)
    ) u_tx (
        .clk, .arst_n, .resend,
        .out_data, .out_vld, .out_ack,
        .route_we, .route_port, .route_leaf, .route_dport,
        .credit_we, .credit_port, .credit_amount,
        .dout
    );

endmodule

// File: leaf_packet_tx.sv
module leaf_packet_tx #(
    parameter int num_out_ports = 5,
    parameter int credit_init   = 4
) (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic                                            resend,
    input  logic [num_out_ports*leaf_pkg::payload_bits-1:0] out_data,
    input  logic [num_out_ports-1:0]                        out_vld,
    output logic [num_out_ports-1:0]                        out_ack,
    input  logic                                            route_we,
    input  logic [leaf_pkg::port_bits-1:0]                  route_port,
    input  logic [leaf_pkg::leaf_bits-1:0]                  route_leaf,
    input  logic [leaf_pkg::port_bits-1:0]                  route_dport,
    input  logic                                            credit_we,
    input  logic [leaf_pkg::port_bits-1:0]                  credit_port,
    input  logic [leaf_pkg::credit_bits-1:0]                credit_amount,
    output logic [leaf_pkg::packet_bits-1:0]                dout
);

    localparam int w        = leaf_pkg::payload_bits;
    localparam int cb       = leaf_pkg::credit_bits;
    localparam int sel_bits = (num_out_ports > 1) ? $clog2(num_out_ports) : 1;

    logic [num_out_ports-1:0]        route_vld;
    logic [leaf_pkg::leaf_bits-1:0]  tbl_leaf [num_out_ports];
    logic [leaf_pkg::port_bits-1:0]  tbl_port [num_out_ports];
    logic [cb-1:0]                   credit [num_out_ports];
    logic [cb-1:0]                   credit_next [num_out_ports];
    logic [leaf_pkg::tag_bits-1:0]   tag_cnt [num_out_ports];
    logic [num_out_ports-1:0]        eligible;
    logic [sel_bits-1:0]             rr_ptr;
    logic [sel_bits-1:0]             sel;
    logic                            grant;
    leaf_pkg::leaf_packet_u          pkt_d;
    logic [leaf_pkg::packet_bits-1:0] dout_r;

    always_comb begin
        for (int k = 0; k < num_out_ports; k++)
            eligible[k] = out_vld[k] && route_vld[k] && (credit[k] != '0) && !resend;
    end

    // Round robin, first eligible port at or after rr_ptr
    always_comb begin
        int unsigned idx;
        grant = 1'b0;
        sel   = rr_ptr;
        for (int i = num_out_ports - 1; i >= 0; i--) begin
            idx = rr_ptr + i;
            if (idx >= num_out_ports)
                idx = idx - num_out_ports;
            if (eligible[idx]) begin
                grant = 1'b1;
                sel   = sel_bits'(idx);
            end
        end
        for (int k = 0; k < num_out_ports; k++)
            out_ack[k] = grant && (sel == k);
    end

    always_comb begin
        pkt_d.data.vld     = 1'b1;
        pkt_d.data.leaf    = tbl_leaf[sel];
        pkt_d.data.port    = tbl_port[sel];
        pkt_d.data.tag     = tag_cnt[sel];
        pkt_d.data.payload = out_data[sel*w +: w];
    end

    // Saturating credit, refill and spend may land together
    always_comb begin
        logic [cb+1:0] sum;
        for (int k = 0; k < num_out_ports; k++) begin
            sum = {2'b00, credit[k]};
            if (credit_we && credit_port == k)
                sum = sum + credit_amount;
            if (out_ack[k])
                sum = sum - 1'b1;
            credit_next[k] = (sum > {2'b00, {cb{1'b1}}}) ? {cb{1'b1}} : sum[cb-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dout_r    <= '0;
            rr_ptr    <= '0;
            route_vld <= '0;
            for (int k = 0; k < num_out_ports; k++) begin
                credit[k]  <= cb'(credit_init);
                tag_cnt[k] <= '0;
            end
        end else begin
            if (!resend)
                dout_r <= grant ? pkt_d : '0;   // Held during resend, goes out again after
            if (grant)
                rr_ptr <= (sel == sel_bits'(num_out_ports - 1)) ? '0 : sel + 1'b1;
            for (int k = 0; k < num_out_ports; k++) begin
                credit[k] <= credit_next[k];
                if (out_ack[k])
                    tag_cnt[k] <= tag_cnt[k] + 1'b1;
                if (route_we && route_port == k)
                    route_vld[k] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < num_out_ports; k++) begin
            if (route_we && route_port == k) begin
                tbl_leaf[k] <= route_leaf;
                tbl_port[k] <= route_dport;
            end
        end
    end

    assign dout = resend ? '0 : dout_r;

    for (genvar k = 0; k < num_out_ports; k++) begin : g_credit_chk
        // A spent credit must leave a smaller count, never wrap
        assert property (@(posedge clk) disable iff (!arst_n)
            out_ack[k] && !(credit_we && credit_port == k) |=> credit[k] < $past(credit[k]));
    end

endmodule

// File: pair_sum_kernel.sv
module pair_sum_kernel #(
    parameter int num_in_ports  = 6,
    parameter int num_out_ports = 5
) (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic [num_in_ports*leaf_pkg::payload_bits-1:0]  in_data,
    input  logic [num_in_ports-1:0]                         in_vld,
    output logic [num_in_ports-1:0]                         in_ack,
    output logic [num_out_ports*leaf_pkg::payload_bits-1:0] out_data,
    output logic [num_out_ports-1:0]                        out_vld,
    input  logic [num_out_ports-1:0]                        out_ack
);

    localparam int w = leaf_pkg::payload_bits;

    logic [num_out_ports-1:0] fire;
    logic [num_out_ports-1:0] used_lo;   // Output k already summed head of input k
    logic [num_out_ports-1:0] used_hi;   // Output k already summed head of input k+1
    logic [num_in_ports-1:0]  by_upper;
    logic [num_in_ports-1:0]  by_lower;

    always_comb begin
        for (int k = 0; k < num_out_ports; k++) begin
            fire[k] = in_vld[k] && in_vld[k+1] && !used_lo[k] && !used_hi[k] &&
                      (!out_vld[k] || out_ack[k]);
        end
    end

    // A shared head is popped once both of its outputs have summed it
    assign by_upper = {1'b1, used_lo | fire};
    assign by_lower = {used_hi | fire, 1'b1};
    assign in_ack   = in_vld & by_upper & by_lower;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_vld <= '0;
            used_lo <= '0;
            used_hi <= '0;
        end else begin
            used_lo <= (used_lo | fire) & ~in_ack[num_out_ports-1:0];
            used_hi <= (used_hi | fire) & ~in_ack[num_in_ports-1:1];
            for (int k = 0; k < num_out_ports; k++) begin
                if (fire[k])
                    out_vld[k] <= 1'b1;
                else if (out_ack[k])
                    out_vld[k] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int k = 0; k < num_out_ports; k++) begin
            if (fire[k])
                out_data[k*w +: w] <= in_data[k*w +: w] + in_data[(k+1)*w +: w];
        end
    end

endmodule

// File: leaf_packet_rx.sv
module leaf_packet_rx #(
    parameter int num_in_ports = 6
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic [leaf_pkg::packet_bits-1:0]   din,
    output logic [num_in_ports-1:0]            fifo_we,
    output logic [leaf_pkg::payload_bits-1:0]  fifo_wdata,
    output logic                               route_we,
    output logic [leaf_pkg::port_bits-1:0]     route_port,
    output logic [leaf_pkg::leaf_bits-1:0]     route_leaf,
    output logic [leaf_pkg::port_bits-1:0]     route_dport,
    output logic                               credit_we,
    output logic [leaf_pkg::port_bits-1:0]     credit_port,
    output logic [leaf_pkg::credit_bits-1:0]   credit_amount
);

    leaf_pkg::leaf_packet_u pkt;
    logic                   is_ctrl;
    logic                   data_ok;

    assign pkt     = din;
    assign is_ctrl = pkt.data.vld && (pkt.data.port == leaf_pkg::ctrl_port);
    assign data_ok = pkt.data.vld && (pkt.data.port >= 1) && (pkt.data.port <= num_in_ports);

    // Strobes, one cycle after the packet
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fifo_we   <= '0;
            route_we  <= 1'b0;
            credit_we <= 1'b0;
        end else begin
            fifo_we   <= '0;
            route_we  <= 1'b0;
            credit_we <= 1'b0;
            if (data_ok)
                fifo_we[pkt.data.port - 1] <= 1'b1;   // Port 1 feeds FIFO 0
            if (is_ctrl) begin
                if (pkt.ctrl.opcode == leaf_pkg::op_route)
                    route_we <= 1'b1;
                else if (pkt.ctrl.opcode == leaf_pkg::op_credit)
                    credit_we <= 1'b1;
                // Other opcodes fall through unused
            end
        end
    end

    always_ff @(posedge clk) begin
        fifo_wdata    <= pkt.data.payload;
        route_port    <= pkt.ctrl.out_port;
        route_leaf    <= pkt.ctrl.dest_leaf;
        route_dport   <= pkt.ctrl.dest_port;
        credit_port   <= pkt.ctrl.out_port;
        credit_amount <= pkt.ctrl.amount;
    end

    assert property (@(posedge clk) disable iff (!arst_n) $onehot0(fifo_we));

endmodule

// File: port_fifo.sv
module port_fifo #(
    parameter int fifo_depth = 8
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              wr_en,
    input  logic [leaf_pkg::payload_bits-1:0] wr_data,
    input  logic                              ack,
    output logic [leaf_pkg::payload_bits-1:0] data,
    output logic                              vld,
    output logic                              full
);

    localparam int addr_bits = $clog2(fifo_depth);

    logic [leaf_pkg::payload_bits-1:0] mem [fifo_depth];
    logic [addr_bits-1:0]              wr_ptr;
    logic [addr_bits-1:0]              rd_ptr;
    logic [addr_bits:0]                count;
    logic                              push;
    logic                              pop;

    assign push = wr_en && !full;
    assign pop  = ack && vld;

    assign data = mem[rd_ptr];   // Show-ahead head word
    assign vld  = (count != '0);
    assign full = (count == (addr_bits + 1)'(fifo_depth));

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == addr_bits'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == addr_bits'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    // Tree side cannot stall, kernel side must wait for vld
    assert property (@(posedge clk) disable iff (!arst_n) !(wr_en && full) && !(ack && !vld));

endmodule

// File: leaf_pkg.sv
package leaf_pkg;

    localparam int packet_bits  = 49;
    localparam int payload_bits = 32;
    localparam int leaf_bits    = 5;
    localparam int port_bits    = 4;
    localparam int tag_bits     = 7;   // Tag in data packets, opcode in control packets
    localparam int credit_bits  = 8;

    // Port 0 is the control port, data ports are 1 and up
    localparam int ctrl_port = 0;

    localparam int op_route  = 0;
    localparam int op_credit = 1;

    typedef struct packed {
        logic                    vld;
        logic [leaf_bits-1:0]    leaf;
        logic [port_bits-1:0]    port;
        logic [tag_bits-1:0]     tag;
        logic [payload_bits-1:0] payload;
    } leaf_data_s;

    typedef struct packed {
        logic                   vld;
        logic [leaf_bits-1:0]   leaf;
        logic [port_bits-1:0]   port;
        logic [tag_bits-1:0]    opcode;
        logic [port_bits-1:0]   out_port;    // Output port the update applies to
        logic [leaf_bits-1:0]   dest_leaf;
        logic [port_bits-1:0]   dest_port;
        logic [credit_bits-1:0] amount;
        logic [10:0]            spare;
    } leaf_ctrl_s;

    // Same 49-bit word, seen as data or as control
    typedef union packed {
        leaf_data_s data;
        leaf_ctrl_s ctrl;
    } leaf_packet_u;

endpackage
